/* hdl/spm_pkg.sv */
/*
 * Shared definitions for the banked scratchpad
 *  - Word, byte strobe, byte address and response typedefs
 *  - AXI response codes used on B and R
 *  - Default bank count and bank depth
 */

package spm_pkg;

    // Word and bus widths
    localparam int DATA_W     = 32;          // Fixed by AXI4-Lite
    localparam int STRB_W     = DATA_W / 8;  // One strobe per byte
    localparam int AXI_ADDR_W = 32;
    localparam int RESP_W     = 2;
    localparam int BYTE_OFS_W = $clog2(STRB_W); // Byte offset bits dropped for word index

    // Vector types
    typedef logic [DATA_W-1:0]     data_t;     // Memory word
    typedef logic [STRB_W-1:0]     strb_t;     // Byte write mask
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t; // AXI byte address
    typedef logic [RESP_W-1:0]     resp_t;     // AXI response code

    // Response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10; // Out of range access

    /* Default geometry, overridden from the top level
       Bank count must stay a power of two for the low-bit interleave */
    localparam int DEF_NUM_BANKS  = 4;
    localparam int DEF_BANK_WORDS = 64;

endpackage

/* hdl/spm_bank.sv */
/*
 * One scratchpad bank
 *  - Inferred dual-port SRAM, one byte lane per strobe bit
 *  - Registered read on each port, unregistered inputs
 *  - Port A for the AXI side, port B for the fabric side
 */

`timescale 1ns/10ps

module spm_bank import spm_pkg::*; #(
    parameter int  BANK_WORDS = DEF_BANK_WORDS,
    localparam int ROW_W      = $clog2(BANK_WORDS)
) (
    input  logic             clk,
    // Port A
    input  logic             en_a,
    input  logic             we_a,
    input  logic [ROW_W-1:0] row_a,
    input  data_t            wdata_a,
    input  strb_t            wmask_a,
    // Port B
    input  logic             en_b,
    input  logic             we_b,
    input  logic [ROW_W-1:0] row_b,
    input  data_t            wdata_b,
    input  strb_t            wmask_b,
    // Read data, one edge after enable
    output data_t            rdata_a,
    output data_t            rdata_b
);

    // Storage as byte lanes so each strobe bit maps to one lane
    logic [STRB_W-1:0][7:0] mem [BANK_WORDS];

    // Port signals gathered so both ports share one body
    logic             en    [2];
    logic             we    [2];
    logic [ROW_W-1:0] row   [2];
    data_t            wdata [2];
    strb_t            wmask [2];
    data_t            rdata [2];

    assign en[0]    = en_a;
    assign we[0]    = we_a;
    assign row[0]   = row_a;
    assign wdata[0] = wdata_a;
    assign wmask[0] = wmask_a;
    assign en[1]    = en_b;
    assign we[1]    = we_b;
    assign row[1]   = row_b;
    assign wdata[1] = wdata_b;
    assign wmask[1] = wmask_b;

    for (genvar p = 0; p < 2; p++) begin : g_port
        always @(posedge clk) begin
            if (en[p]) begin
                if (we[p]) begin
                    for (int j = 0; j < STRB_W; j++) begin
                        if (wmask[p][j]) mem[row[p]][j] <= wdata[p][j*8 +: 8]; // Masked byte
                    end
                end
                rdata[p] <= mem[row[p]]; // Old word on a same-port write
            end
        end
    end : g_port

    assign rdata_a = rdata[0];
    assign rdata_b = rdata[1];

endmodule

/* hdl/axil_slave.sv */
/*
 * AXI4-Lite slave for the scratchpad
 *  - One transaction at a time, writes take priority over reads
 *  - Issues a single-cycle memory request per accepted transaction
 *  - Forms B and R responses from the range check of the router
 */

`timescale 1ns/10ps

module axil_slave import spm_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    // Write address
    input  logic      awvalid,
    output logic      awready,
    input  axi_addr_t awaddr,
    // Write data
    input  logic      wvalid,
    output logic      wready,
    input  data_t     wdata,
    input  strb_t     wstrb,
    // Write response
    output logic      bvalid,
    input  logic      bready,
    output resp_t     bresp,
    // Read address
    input  logic      arvalid,
    output logic      arready,
    input  axi_addr_t araddr,
    // Read data
    output logic      rvalid,
    input  logic      rready,
    output data_t     rdata,
    output resp_t     rresp,
    // Memory request toward the router
    output logic      req_valid,
    output logic      req_we,
    output axi_addr_t req_addr,
    output data_t     req_wdata,
    output strb_t     req_wstrb,
    input  logic      req_err,     // Combinational range check
    // Read return from the collector
    input  data_t     rd_data_a,
    input  logic      rd_valid_a
);

    typedef enum logic [1:0] {
        IDLE,   // Waiting for a write pair or a read
        WRESP,  // Write issued, B pending
        RWAIT,  // Read in the bank and collector pipe
        RRESP   // R pending
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   live;      // Low until the first edge out of reset
    logic   wr_pair;   // Both write channels presented
    logic   wr_go;
    logic   rd_go;
    resp_t  resp_q;    // Response of the current transaction
    data_t  rdata_q;   // Collector word held under back-pressure

    assign wr_pair = awvalid && wvalid;
    assign wr_go   = live && (state == IDLE) && wr_pair;
    assign rd_go   = live && (state == IDLE) && arvalid && !wr_pair; // Write wins

    // Ready only in IDLE, so every ready drops while a response waits
    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = live && (state == IDLE) && !wr_pair;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (wr_go)      state_nxt = WRESP;
                else if (rd_go) state_nxt = RWAIT;
            end
            WRESP:   if (bvalid && bready) state_nxt = IDLE;
            RWAIT:   if (!req_valid) state_nxt = RRESP; // Second wait cycle
            RRESP:   if (rvalid && rready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // Control state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            live      <= 1'b0;
            req_valid <= 1'b0;
            req_we    <= 1'b0;
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            resp_q    <= RESP_OKAY;
        end else begin
            state     <= state_nxt;
            live      <= 1'b1;
            req_valid <= wr_go || rd_go; // One cycle per transaction
            if (wr_go || rd_go) req_we <= wr_go;

            // Range check sampled while the request is out
            if (req_valid) resp_q <= req_err ? RESP_SLVERR : RESP_OKAY;

            // B one cycle after the handshake
            if (state == WRESP && req_valid) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end

            // R two edges after the handshake, lined up with the collector
            if (state == RWAIT && !req_valid) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (wr_go) begin
            req_addr  <= awaddr;
            req_wdata <= wdata;
            req_wstrb <= wstrb;
        end else if (rd_go) begin
            req_addr  <= araddr;
        end
        if (rd_valid_a) rdata_q <= rd_data_a; // Keep word past the collector pulse
    end

    assign bresp = resp_q;
    assign rresp = resp_q;

    // Collector word on its first cycle, held copy afterwards, zero on error
    always_comb begin
        if (resp_q == RESP_SLVERR) begin
            rdata = '0;
        end else if (rd_valid_a) begin
            rdata = rd_data_a;
        end else begin
            rdata = rdata_q;
        end
    end

endmodule

/* hdl/bank_router.sv */
/*
 * Request router for the bank array
 *  - Word index split into low-bit bank select and high-bit row
 *  - Range check of the AXI byte address
 *  - One-hot enables per bank for both ports
 */

`timescale 1ns/10ps

module bank_router import spm_pkg::*; #(
    parameter int  NUM_BANKS  = DEF_NUM_BANKS,
    parameter int  BANK_WORDS = DEF_BANK_WORDS,
    localparam int SEL_W      = $clog2(NUM_BANKS),
    localparam int ROW_W      = $clog2(BANK_WORDS),
    localparam int WADDR_W    = SEL_W + ROW_W
) (
    // Port A request from the slave
    input  logic                 req_valid,
    input  logic                 req_we,
    input  axi_addr_t            req_addr,
    input  data_t                req_wdata,
    input  strb_t                req_wstrb,
    output logic                 req_err,
    // Port B from the fabric
    input  logic                 fab_en,
    input  logic                 fab_we,
    input  logic [WADDR_W-1:0]   fab_addr,  // Word address
    input  data_t                fab_wdata,
    input  strb_t                fab_wmask,
    // Bank controls
    output logic [NUM_BANKS-1:0] bank_en_a,
    output logic [NUM_BANKS-1:0] bank_we_a,
    output logic [NUM_BANKS-1:0] bank_en_b,
    output logic [NUM_BANKS-1:0] bank_we_b,
    output logic [ROW_W-1:0]     row_a,
    output logic [ROW_W-1:0]     row_b,
    output data_t                wdata_a,
    output strb_t                wmask_a,
    output data_t                wdata_b,
    output strb_t                wmask_b,
    // Read tags for the collector
    output logic [SEL_W-1:0]     sel_a,
    output logic [SEL_W-1:0]     sel_b,
    output logic                 rd_a,
    output logic                 rd_b
);

    localparam int MEM_WORDS = NUM_BANKS * BANK_WORDS;

    logic [AXI_ADDR_W-BYTE_OFS_W-1:0] word_a; // Byte offset dropped
    logic                             go_a;

    assign word_a  = req_addr[AXI_ADDR_W-1:BYTE_OFS_W];
    assign req_err = (word_a >= MEM_WORDS);
    assign go_a    = req_valid && !req_err; // No bank sees an out of range access

    // Interleave on the low word bits
    assign sel_a = word_a[SEL_W-1:0];
    assign row_a = word_a[SEL_W +: ROW_W];
    assign sel_b = fab_addr[SEL_W-1:0];
    assign row_b = fab_addr[SEL_W +: ROW_W];

    assign rd_a = go_a && !req_we;
    assign rd_b = fab_en && !fab_we;

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_en_a[i] = go_a && (sel_a == SEL_W'(i));
            bank_we_a[i] = bank_en_a[i] && req_we;
            bank_en_b[i] = fab_en && (sel_b == SEL_W'(i));
            bank_we_b[i] = bank_en_b[i] && fab_we;
        end
    end

    // Write payload shared by every bank
    assign wdata_a = req_wdata;
    assign wmask_a = req_wstrb;
    assign wdata_b = fab_wdata;
    assign wmask_b = fab_wmask;

endmodule

/* hdl/read_collect.sv */
/*
 * Read collector for the bank array
 *  - Select and read flag delayed to meet the registered bank read
 *  - Bank word mux and output register per port
 *  - Valid pulse for port A, held data for the fabric port
 */

`timescale 1ns/10ps

module read_collect import spm_pkg::*; #(
    parameter int  NUM_BANKS = DEF_NUM_BANKS,
    localparam int SEL_W     = $clog2(NUM_BANKS)
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [SEL_W-1:0]      sel_a,
    input  logic                  rd_a,
    input  logic [SEL_W-1:0]      sel_b,
    input  logic                  rd_b,
    input  data_t [NUM_BANKS-1:0] bank_rdata_a,
    input  data_t [NUM_BANKS-1:0] bank_rdata_b,
    output data_t                 rd_data_a,
    output logic                  rd_valid_a,  // Two edges after the request
    output data_t                 fab_rdata
);

    logic [SEL_W-1:0] sel_a_q;  // Bank of the read now leaving the banks
    logic [SEL_W-1:0] sel_b_q;
    logic             rd_a_q;
    logic             rd_b_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_a_q     <= 1'b0;
            rd_b_q     <= 1'b0;
            rd_valid_a <= 1'b0;
        end else begin
            rd_a_q     <= rd_a;   // Stage 1, bank read
            rd_b_q     <= rd_b;
            rd_valid_a <= rd_a_q; // Stage 2, word registered
        end
    end

    always_ff @(posedge clk) begin
        sel_a_q <= sel_a;
        sel_b_q <= sel_b;
        if (rd_a_q) rd_data_a <= bank_rdata_a[sel_a_q];
        if (rd_b_q) fab_rdata <= bank_rdata_b[sel_b_q]; // Holds between reads
    end

endmodule

/* hdl/spm_top.sv */
/*
 * Banked scratchpad top level
 *  - AXI4-Lite slave on bank port A
 *  - Fixed latency fabric port on bank port B
 *  - Router, bank array and read collector
 */

`timescale 1ns/10ps

module spm_top import spm_pkg::*; #(
    parameter int  NUM_BANKS  = DEF_NUM_BANKS,
    parameter int  BANK_WORDS = DEF_BANK_WORDS,
    localparam int SEL_W      = $clog2(NUM_BANKS),
    localparam int ROW_W      = $clog2(BANK_WORDS),
    localparam int WADDR_W    = SEL_W + ROW_W
) (
    input  logic               clk,
    input  logic               arst_n,
    // AXI4-Lite
    input  logic               awvalid,
    output logic               awready,
    input  axi_addr_t          awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  data_t              wdata,
    input  strb_t              wstrb,
    output logic               bvalid,
    input  logic               bready,
    output resp_t              bresp,
    input  logic               arvalid,
    output logic               arready,
    input  axi_addr_t          araddr,
    output logic               rvalid,
    input  logic               rready,
    output data_t              rdata,
    output resp_t              rresp,
    // Fabric port
    input  logic               fab_en,
    input  logic               fab_we,
    input  logic [WADDR_W-1:0] fab_addr,
    input  data_t              fab_wdata,
    input  strb_t              fab_wmask,
    output data_t              fab_rdata
);

    // Slave request
    logic      req_valid;
    logic      req_we;
    axi_addr_t req_addr;
    data_t     req_wdata;
    strb_t     req_wstrb;
    logic      req_err;

    // Bank controls, shared row and payload per port
    logic [NUM_BANKS-1:0] bank_en_a;
    logic [NUM_BANKS-1:0] bank_we_a;
    logic [NUM_BANKS-1:0] bank_en_b;
    logic [NUM_BANKS-1:0] bank_we_b;
    logic [ROW_W-1:0]     row_a;
    logic [ROW_W-1:0]     row_b;
    data_t                wdata_a;
    strb_t                wmask_a;
    data_t                wdata_b;
    strb_t                wmask_b;

    // Read path
    data_t [NUM_BANKS-1:0] bank_rdata_a;
    data_t [NUM_BANKS-1:0] bank_rdata_b;
    logic [SEL_W-1:0]      sel_a;
    logic [SEL_W-1:0]      sel_b;
    logic                  rd_a;
    logic                  rd_b;
    data_t                 rd_data_a;
    logic                  rd_valid_a;

    axil_slave u_slave (
        .clk, .arst_n,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp,
        .req_valid, .req_we, .req_addr, .req_wdata, .req_wstrb, .req_err,
        .rd_data_a, .rd_valid_a
    );

    bank_router #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) u_router (
        .req_valid, .req_we, .req_addr, .req_wdata, .req_wstrb, .req_err,
        .fab_en, .fab_we, .fab_addr, .fab_wdata, .fab_wmask,
        .bank_en_a, .bank_we_a, .bank_en_b, .bank_we_b,
        .row_a, .row_b, .wdata_a, .wmask_a, .wdata_b, .wmask_b,
        .sel_a, .sel_b, .rd_a, .rd_b
    );

    // One bank per low word-address value
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        spm_bank #(.BANK_WORDS(BANK_WORDS)) u_bank (
            .clk,
            .en_a(bank_en_a[i]), .we_a(bank_we_a[i]), .row_a, .wdata_a, .wmask_a,
            .en_b(bank_en_b[i]), .we_b(bank_we_b[i]), .row_b, .wdata_b, .wmask_b,
            .rdata_a(bank_rdata_a[i]),
            .rdata_b(bank_rdata_b[i])
        );
    end : g_bank

    read_collect #(.NUM_BANKS(NUM_BANKS)) u_collect (
        .clk, .arst_n,
        .sel_a, .rd_a, .sel_b, .rd_b,
        .bank_rdata_a, .bank_rdata_b,
        .rd_data_a, .rd_valid_a, .fab_rdata
    );

endmodule

/* sim/spm_tb.sv */
/*
 * Testbench for the banked scratchpad
 *  - Loads operations and expected values from the data file
 *  - AXI4-Lite write and read tasks with optional response back-pressure
 *  - Fabric port write and fixed latency read tasks
 *  - Compare tasks for words, response codes and control flags
 */

`timescale 1ns/10ps

module spm_tb import spm_pkg::*;;

    localparam int NUM_BANKS   = DEF_NUM_BANKS;
    localparam int BANK_WORDS  = DEF_BANK_WORDS;
    localparam int WADDR_W     = $clog2(NUM_BANKS) + $clog2(BANK_WORDS);
    localparam int REC_W       = 6;       // Words per record
    localparam int MAX_RECS    = 64;
    localparam int TIMEOUT     = 50;      // Cycles per wait
    localparam int HOLD_CYCLES = 5;       // Back-pressure length

    // Operation codes in the data file
    localparam logic [31:0] OP_AXI_WR      = 32'h0;
    localparam logic [31:0] OP_AXI_RD      = 32'h1;
    localparam logic [31:0] OP_FAB_WR      = 32'h2;
    localparam logic [31:0] OP_FAB_RD      = 32'h3;
    localparam logic [31:0] OP_AXI_WR_HOLD = 32'h4;
    localparam logic [31:0] OP_AXI_RD_HOLD = 32'h5;
    localparam logic [31:0] OP_END         = 32'hf;

    // Channel codes for the wait loop
    localparam int CH_AW = 0;
    localparam int CH_B  = 1;
    localparam int CH_AR = 2;
    localparam int CH_R  = 3;

    logic clk;
    logic arst_n;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    axi_addr_t awaddr, araddr;
    data_t     wdata, rdata;
    strb_t     wstrb;
    resp_t     bresp, rresp;
    logic      fab_en, fab_we;
    logic [WADDR_W-1:0] fab_addr;
    data_t     fab_wdata, fab_rdata;
    strb_t     fab_wmask;

    logic [31:0] tv [REC_W*MAX_RECS];  // Flat record storage

    spm_top #(.NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) u_dut (.*);

    always #4 clk = ~clk;  // 8 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp)
            abort_run($sformatf("FAILED t=%0t %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (act !== exp)
            abort_run($sformatf("FAILED t=%0t %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("FAILED t=%0t %s expected %b got %b", $time, name, exp, act));
    endtask

    function automatic logic channel_active(input int ch);
        case (ch)
            CH_AW:   return awready && wready;
            CH_B:    return bvalid;
            CH_AR:   return arready;
            default: return rvalid;
        endcase
    endfunction

    // Leaves on the falling edge where the channel is up
    task automatic wait_channel(input int ch, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!channel_active(ch)) begin
            n++;
            if (n >= TIMEOUT) abort_run($sformatf("Timeout, %s channel hung", name));
            @(negedge clk);
        end
    endtask

    task automatic axi_write(input axi_addr_t addr, input data_t data, input strb_t strb,
                             input resp_t exp_resp, input int hold);
        int i;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        wait_channel(CH_AW, "write address and data");
        @(posedge clk);   // AW and W handshake
        #1;
        awvalid = (hold > 0);  // Same write queued behind a held response
        wvalid  = (hold > 0);
        wait_channel(CH_B, "write response");
        for (i = 0; i < hold; i++) begin
            check_bit("bvalid", 1'b1, bvalid);  // Held under back-pressure
            check_resp("bresp", exp_resp, bresp);
            check_bit("awready", 1'b0, awready);  // Queued pair has to wait
            check_bit("wready", 1'b0, wready);
            @(negedge clk);
        end
        if (hold > 0) begin
            @(posedge clk);
            #1;
            bready = 1'b1;
            @(negedge clk);
            check_bit("bvalid", 1'b1, bvalid);
        end
        check_resp("bresp", exp_resp, bresp);
        @(posedge clk);   // B handshake
        #1;
        bready = 1'b0;
        if (hold > 0) begin
            // Queued copy rewrites the same bytes once back in IDLE
            wait_channel(CH_AW, "queued write address and data");
            @(posedge clk);
            #1;
            awvalid = 1'b0;
            wvalid  = 1'b0;
            bready  = 1'b1;
            wait_channel(CH_B, "queued write response");
            check_resp("bresp", exp_resp, bresp);
            @(posedge clk);
            #1;
            bready = 1'b0;
        end
    endtask

    task automatic axi_read(input axi_addr_t addr, input data_t exp_data,
                            input resp_t exp_resp, input int hold);
        int i;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        wait_channel(CH_AR, "read address");
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        wait_channel(CH_R, "read data");
        for (i = 0; i < hold; i++) begin
            check_bit("rvalid", 1'b1, rvalid);
            check_data("rdata", exp_data, rdata);  // Stable past the collector pulse
            check_resp("rresp", exp_resp, rresp);
            check_bit("arready", 1'b0, arready);
            @(negedge clk);
        end
        if (hold > 0) begin
            @(posedge clk);
            #1;
            rready = 1'b1;
            @(negedge clk);
            check_bit("rvalid", 1'b1, rvalid);
        end
        check_data("rdata", exp_data, rdata);
        check_resp("rresp", exp_resp, rresp);
        @(posedge clk);   // R handshake
        #1;
        rready = 1'b0;
    endtask

    task automatic fab_write(input logic [WADDR_W-1:0] addr, input data_t data,
                             input strb_t mask);
        fab_addr  = addr;
        fab_wdata = data;
        fab_wmask = mask;
        fab_en    = 1'b1;
        fab_we    = 1'b1;
        @(posedge clk);   // Bank write
        #1;
        fab_en = 1'b0;
        fab_we = 1'b0;
    endtask

    // fab_rdata checked two edges after the enable cycle
    task automatic fab_read(input logic [WADDR_W-1:0] addr, input data_t exp_data);
        fab_addr = addr;
        fab_en   = 1'b1;
        fab_we   = 1'b0;
        @(posedge clk);   // Bank read
        #1;
        fab_en = 1'b0;
        @(posedge clk);   // Collector register
        #1;
        check_data("fab_rdata", exp_data, fab_rdata);
    endtask

    initial begin
        int          r;
        int          n_ops;
        logic [31:0] op;
        axi_addr_t   addr;
        data_t       data;
        strb_t       strb;
        data_t       exp_data;
        resp_t       exp_resp;

        clk       = 1'b0;
        arst_n    = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        fab_en    = 1'b0;
        fab_we    = 1'b0;
        fab_addr  = '0;
        fab_wdata = '0;
        fab_wmask = '0;
        n_ops     = 0;
        op        = 'x;
        $readmemh("sim/spm_testdata.txt", tv);

        repeat (8) @(posedge clk);
        #1;
        check_bit("arready", 1'b0, arready);  // Read side closed in reset
        check_bit("bvalid", 1'b0, bvalid);
        check_bit("rvalid", 1'b0, rvalid);
        arst_n = 1'b1;
        @(posedge clk);
        #1;

        for (r = 0; r < MAX_RECS; r++) begin
            op       = tv[r*REC_W];
            addr     = tv[r*REC_W + 1];
            data     = tv[r*REC_W + 2];
            strb     = tv[r*REC_W + 3][STRB_W-1:0];
            exp_data = tv[r*REC_W + 4];
            exp_resp = tv[r*REC_W + 5][RESP_W-1:0];
            if (op === OP_END) break;
            case (op)
                OP_AXI_WR:      axi_write(addr, data, strb, exp_resp, 0);
                OP_AXI_RD:      axi_read(addr, exp_data, exp_resp, 0);
                OP_FAB_WR:      fab_write(addr[WADDR_W-1:0], data, strb);
                OP_FAB_RD:      fab_read(addr[WADDR_W-1:0], exp_data);
                OP_AXI_WR_HOLD: axi_write(addr, data, strb, exp_resp, HOLD_CYCLES);
                OP_AXI_RD_HOLD: axi_read(addr, exp_data, exp_resp, HOLD_CYCLES);
                default: abort_run($sformatf("Unknown operation %h in record %0d", op, r));
            endcase
            n_ops++;
        end

        if (n_ops > 0 && op === OP_END) begin
            $display("All checks passed");
            $finish;
        end else begin
            abort_run("Test data was empty or had no end marker");
        end
    end

endmodule

/* sim/spm_testdata.txt */
// op addr data mask exp_data exp_resp, all hex, one operation per line
// op 0/1 AXI write/read, 2/3 fabric write/read by word address, 4/5 AXI held off, f end
// Write then read back
0 00000010 12345678 f 00000000 0
1 00000010 00000000 0 12345678 0
// Partial strobes merge into the old word
0 00000020 aabbccdd f 00000000 0
0 00000020 11223344 5 00000000 0
1 00000020 00000000 0 aa22cc44 0
0 00000020 99887766 a 00000000 0
1 00000020 00000000 0 99227744 0
// Consecutive words over all banks and two rows, read back in reverse
0 00000040 c0000010 f 00000000 0
0 00000044 c1000011 f 00000000 0
0 00000048 c2000012 f 00000000 0
0 0000004c c3000013 f 00000000 0
0 00000050 c4000014 f 00000000 0
0 00000054 c5000015 f 00000000 0
0 00000058 c6000016 f 00000000 0
0 0000005c c7000017 f 00000000 0
0 000003fc e00000ff f 00000000 0
1 000003fc 00000000 0 e00000ff 0
1 0000005c 00000000 0 c7000017 0
1 00000058 00000000 0 c6000016 0
1 00000054 00000000 0 c5000015 0
1 00000050 00000000 0 c4000014 0
1 0000004c 00000000 0 c3000013 0
1 00000048 00000000 0 c2000012 0
1 00000044 00000000 0 c1000011 0
1 00000040 00000000 0 c0000010 0
// Cross-port visibility
2 00000030 5a5a0001 f 00000000 0
1 000000c0 00000000 0 5a5a0001 0
0 000000c4 0badf00d f 00000000 0
3 00000031 00000000 0 0badf00d 0
2 00000031 000000ee 1 00000000 0
3 00000031 00000000 0 0badf0ee 0
// Out of range, word 0 shares the low bits
0 00000000 13579bdf f 00000000 0
0 00000400 ffffffff f 00000000 2
1 00000400 00000000 0 00000000 2
1 00000000 00000000 0 13579bdf 0
3 00000000 00000000 0 13579bdf 0
// Responses held off by the master
4 00000080 2468ace0 f 00000000 0
5 00000080 00000000 0 2468ace0 0
4 00000800 0f0f0f0f f 00000000 2
5 00001000 00000000 0 00000000 2
f 00000000 00000000 0 00000000 0

/* filelist.f */
hdl/spm_pkg.sv
hdl/spm_bank.sv
hdl/axil_slave.sv
hdl/bank_router.sv
hdl/read_collect.sv
hdl/spm_top.sv
sim/spm_tb.sv
